// ==== logic/zorro_video_pkg.sv ====
package zorro_video_pkg;

  ////////////////////////////////////////////////////////////
  // bus widths and address map
  ////////////////////////////////////////////////////////////

  localparam int ZADDR_W = 24;
  localparam int ZDATA_W = 16;

  // frame buffer window in zorro ii space
  localparam logic [ZADDR_W-1:0] RAM_LOW  = 24'h600000;
  localparam logic [ZADDR_W-1:0] RAM_HIGH = 24'h740000;

  // autoconfig window, upper bound exclusive
  localparam logic [ZADDR_W-1:0] ROM_LOW  = 24'he80000;
  localparam logic [ZADDR_W-1:0] ROM_HIGH = 24'he80100;

  ////////////////////////////////////////////////////////////
  // bus side types
  ////////////////////////////////////////////////////////////

  // raw bus inputs, strobes active low
  typedef struct packed {
    logic               cfgin_n;
    logic               as_n;
    logic               uds_n;
    logic               lds_n;
    logic               read;
    logic               doe;
    logic [ZADDR_W-1:0] addr;
    logic [ZDATA_W-1:0] data;
  } zorro_in_t;

  // one captured host write
  typedef struct packed {
    logic               ube;
    logic               lbe;
    logic [ZADDR_W-2:0] index;
    logic [ZDATA_W-1:0] data;
  } wq_entry_t;

  ////////////////////////////////////////////////////////////
  // display side types
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [4:0] blue;
    logic [5:0] green;
    logic [4:0] red;
  } rgb565_t;

  // stored raw, decoded as rgb565 at scanout
  typedef union packed {
    logic [ZDATA_W-1:0] raw;
    rgb565_t            rgb;
  } pixel_u;

  typedef struct packed {
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;
    logic       hsync;
    logic       vsync;
    logic       blank;
  } video_out_t;

endpackage

// ==== logic/autoconfig_rom.sv ====
module autoconfig_rom (
  input  logic                                 vga_clk,
  input  logic                                 reset,
  input  logic [7:0]                           offset,
  output logic [zorro_video_pkg::ZDATA_W-1:0] rom_data
);

  logic [3:0] nibble;

  // autoconfig nibbles, only the upper data nibble is meaningful
  always_comb begin
    case (offset)
      8'h00:   nibble = 4'hc;  // zorro ii board type
      8'h02:   nibble = 4'h7;  // 4mb, not linked
      8'h04:   nibble = 4'h1;  // product number
      8'h06:   nibble = 4'h7;
      8'h08:   nibble = 4'h4;  // flags
      // manufacturer id
      8'h10:   nibble = 4'h6;
      8'h12:   nibble = 4'hd;
      8'h14:   nibble = 4'h6;
      8'h16:   nibble = 4'hd;
      default: nibble = 4'h0;
    endcase
  end

  // one cycle lookup
  always_ff @(posedge vga_clk) begin
    if (reset) begin
      rom_data <= '0;
    end else begin
      rom_data <= {nibble, 12'h000};
    end
  end

endmodule

// ==== logic/zorro_bus_slave.sv ====
module zorro_bus_slave #(
  parameter int LINE_WORDS = 2048
) (
  input  logic                                 vga_clk,
  input  logic                                 reset,
  input  zorro_video_pkg::zorro_in_t          bus,
  output logic [7:0]                           rom_offset,
  input  logic [zorro_video_pkg::ZDATA_W-1:0] rom_data,
  output logic                                 slave_n,
  output logic                                 dir,
  output logic [zorro_video_pkg::ZDATA_W-1:0] data_out,
  output logic                                 data_oe,
  output logic                                 push,
  output zorro_video_pkg::wq_entry_t          push_entry
);

  localparam int IDX_W = $clog2(LINE_WORDS);

  localparam logic [1:0] ST_IDLE       = 2'd0;
  localparam logic [1:0] ST_ROM_READ   = 2'd1;
  localparam logic [1:0] ST_WRITE_WAIT = 2'd2;
  localparam logic [1:0] ST_WRITE_DONE = 2'd3;

  logic [1:0] state;

  // control synchronizers, strobes get an extra stage for the stability check
  logic [1:0] as_sync;
  logic [1:0] cfgin_sync;
  logic [1:0] read_sync;
  logic [1:0] doe_sync;
  logic [2:0] uds_sync;
  logic [2:0] lds_sync;

  logic [zorro_video_pkg::ZADDR_W-1:0] zaddr;
  logic [zorro_video_pkg::ZDATA_W-1:0] zdata;
  logic [zorro_video_pkg::ZADDR_W-1:0] ram_off;
  logic [zorro_video_pkg::ZADDR_W-2:0] wr_index;

  logic in_rom;
  logic in_ram;
  logic strobes_stable;

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      as_sync    <= 2'b11;
      cfgin_sync <= 2'b11;
      read_sync  <= 2'b00;
      doe_sync   <= 2'b00;
      uds_sync   <= 3'b111;
      lds_sync   <= 3'b111;
    end else begin
      as_sync    <= {as_sync[0], bus.as_n};
      cfgin_sync <= {cfgin_sync[0], bus.cfgin_n};
      read_sync  <= {read_sync[0], bus.read};
      doe_sync   <= {doe_sync[0], bus.doe};
      uds_sync   <= {uds_sync[1:0], bus.uds_n};
      lds_sync   <= {lds_sync[1:0], bus.lds_n};
    end
  end

  // address and data need only one stage
  always_ff @(posedge vga_clk) begin
    zaddr <= bus.addr;
    zdata <= bus.data;
  end

  ////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////

  assign in_rom  = (zaddr >= zorro_video_pkg::ROM_LOW) && (zaddr < zorro_video_pkg::ROM_HIGH);
  assign in_ram  = (zaddr >= zorro_video_pkg::RAM_LOW) && (zaddr < zorro_video_pkg::RAM_HIGH);
  assign ram_off = zaddr - zorro_video_pkg::RAM_LOW;

  // same level over two samples, at least one strobe low
  assign strobes_stable = (uds_sync[2] == uds_sync[1]) && (lds_sync[2] == lds_sync[1]) &&
                          (!uds_sync[2] || !lds_sync[2]);

  assign rom_offset = zaddr[7:0];

  ////////////////////////////////////////////////////////////
  // slave fsm
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      state <= ST_IDLE;
      push  <= 1'b0;
    end else begin
      push <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (!as_sync[1]) begin
            if (read_sync[1] && in_rom && !cfgin_sync[1] && doe_sync[1]) begin
              state <= ST_ROM_READ;
            end else if (!read_sync[1] && in_ram) begin
              state <= ST_WRITE_WAIT;
            end
            // ram reads get no answer
          end
        end
        ST_ROM_READ: begin
          if (!doe_sync[1]) begin
            state <= ST_IDLE;
          end
        end
        ST_WRITE_WAIT: begin
          if (strobes_stable) begin
            push  <= 1'b1;
            state <= ST_WRITE_DONE;
          end
        end
        default: begin
          if (as_sync[1]) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // write address latched at decode, data and enables at capture
  always_ff @(posedge vga_clk) begin
    if (state == ST_IDLE) begin
      wr_index <= (zorro_video_pkg::ZADDR_W - 1)'(ram_off[IDX_W:1]);
    end
    if (state == ST_WRITE_WAIT && strobes_stable) begin
      push_entry.ube   <= !uds_sync[2];
      push_entry.lbe   <= !lds_sync[2];
      push_entry.index <= wr_index;
      push_entry.data  <= zdata;
    end
  end

  assign data_oe  = (state == ST_ROM_READ);
  assign data_out = rom_data;
  assign dir      = !data_oe;
  assign slave_n  = !(data_oe && doe_sync[1] && read_sync[1]);

  // one entry per host write
  assert property (@(posedge vga_clk) disable iff (reset) push |=> !push)
    else $error("write pushed on two consecutive cycles");

endmodule

// ==== logic/write_queue.sv ====
module write_queue #(
  parameter int QUEUE_DEPTH = 16
) (
  input  logic                       vga_clk,
  input  logic                       reset,
  input  logic                       push,
  input  zorro_video_pkg::wq_entry_t push_entry,
  input  logic                       pop,
  output zorro_video_pkg::wq_entry_t head,
  output logic                       not_empty
);

  localparam int PTR_W = $clog2(QUEUE_DEPTH);

  zorro_video_pkg::wq_entry_t mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] fill_ptr;
  logic [PTR_W-1:0] drain_ptr;
  logic [PTR_W:0]   count;
  logic             full;

  assign full      = (count == (PTR_W + 1)'(QUEUE_DEPTH));
  assign not_empty = (count != '0);
  assign head      = mem[drain_ptr];

  always_ff @(posedge vga_clk) begin
    if (push) begin
      mem[fill_ptr] <= push_entry;
    end
  end

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      fill_ptr  <= '0;
      drain_ptr <= '0;
      count     <= '0;
    end else begin
      if (push) begin
        fill_ptr <= (fill_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : fill_ptr + 1'b1;
      end
      if (pop) begin
        drain_ptr <= (drain_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : drain_ptr + 1'b1;
      end
      count <= count + (PTR_W + 1)'(push) - (PTR_W + 1)'(pop);
    end
  end

  // drain side lives in the line buffer
  assert property (@(posedge vga_clk) disable iff (reset) push |-> !full)
    else $error("write queue overflow");
  assert property (@(posedge vga_clk) disable iff (reset) pop |-> not_empty)
    else $error("write queue popped while empty");

endmodule

// ==== logic/line_buffer.sv ====
module line_buffer #(
  parameter int LINE_WORDS = 2048
) (
  input  logic                         vga_clk,
  input  logic                         reset,
  input  zorro_video_pkg::wq_entry_t   head,
  input  logic                         not_empty,
  output logic                         pop,
  input  logic [$clog2(LINE_WORDS)-1:0] rd_index,
  output zorro_video_pkg::pixel_u      rd_pixel
);

  localparam int IDX_W = $clog2(LINE_WORDS);

  logic [zorro_video_pkg::ZDATA_W-1:0] mem [LINE_WORDS];
  logic [IDX_W-1:0]                    wr_index;

  // one entry per cycle, queue never waits
  assign pop      = not_empty;
  assign wr_index = head.index[IDX_W-1:0];

  ////////////////////////////////////////////////////////////
  // write port with byte enables
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      for (int i = 0; i < LINE_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (not_empty) begin
      if (head.ube) begin
        mem[wr_index][15:8] <= head.data[15:8];
      end
      if (head.lbe) begin
        mem[wr_index][7:0] <= head.data[7:0];
      end
    end
  end

  // scanout read, one cycle
  always_ff @(posedge vga_clk) begin
    if (reset) begin
      rd_pixel.raw <= '0;
    end else begin
      rd_pixel.raw <= mem[rd_index];
    end
  end

endmodule

// ==== logic/video_timing.sv ====
module video_timing #(
  parameter int H_ACTIVE     = 1280,
  parameter int H_SYNC_START = 1352,
  parameter int H_SYNC_END   = 1360,
  parameter int H_TOTAL      = 1648,
  parameter int V_ACTIVE     = 720,
  parameter int V_SYNC_START = 723,
  parameter int V_SYNC_END   = 728,
  parameter int V_TOTAL      = 750,
  parameter int LINE_WORDS   = 2048
) (
  input  logic                           vga_clk,
  input  logic                           reset,
  output logic [$clog2(LINE_WORDS)-1:0]  rd_index,
  input  zorro_video_pkg::pixel_u        rd_pixel,
  output zorro_video_pkg::video_out_t    video
);

  localparam int X_W   = $clog2(H_TOTAL);
  localparam int Y_W   = $clog2(V_TOTAL);
  localparam int IDX_W = $clog2(LINE_WORDS);

  logic [X_W-1:0] x;
  logic [Y_W-1:0] y;

  // stage 1, aligned with the line buffer read
  logic active_d1;
  logic hsync_d1;
  logic vsync_d1;

  ////////////////////////////////////////////////////////////
  // counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      x <= '0;
      y <= '0;
    end else if (x == X_W'(H_TOTAL - 1)) begin
      x <= '0;
      y <= (y == Y_W'(V_TOTAL - 1)) ? '0 : y + 1'b1;
    end else begin
      x <= x + 1'b1;
    end
  end

  assign rd_index = IDX_W'(x);

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      active_d1 <= 1'b0;
      hsync_d1  <= 1'b0;
      vsync_d1  <= 1'b0;
    end else begin
      active_d1 <= (x < X_W'(H_ACTIVE)) && (y < Y_W'(V_ACTIVE));
      hsync_d1  <= (x >= X_W'(H_SYNC_START)) && (x < X_W'(H_SYNC_END));
      vsync_d1  <= (y >= Y_W'(V_SYNC_START)) && (y < Y_W'(V_SYNC_END));
    end
  end

  ////////////////////////////////////////////////////////////
  // output stage, rgb565 widened by repeating msbs
  ////////////////////////////////////////////////////////////

  always_ff @(posedge vga_clk) begin
    if (reset) begin
      video <= '{red: 8'h00, green: 8'h00, blue: 8'h00,
                 hsync: 1'b0, vsync: 1'b0, blank: 1'b1};
    end else begin
      video.hsync <= hsync_d1;
      video.vsync <= vsync_d1;
      video.blank <= !active_d1;
      if (active_d1) begin
        video.red   <= {rd_pixel.rgb.red, rd_pixel.rgb.red[4:2]};
        video.green <= {rd_pixel.rgb.green, rd_pixel.rgb.green[5:4]};
        video.blue  <= {rd_pixel.rgb.blue, rd_pixel.rgb.blue[4:2]};
      end else begin
        video.red   <= 8'h00;
        video.green <= 8'h00;
        video.blue  <= 8'h00;
      end
    end
  end

endmodule

// ==== logic/zorro_video_top.sv ====
module zorro_video_top #(
  parameter int H_ACTIVE     = 1280,
  parameter int H_SYNC_START = 1352,
  parameter int H_SYNC_END   = 1360,
  parameter int H_TOTAL      = 1648,
  parameter int V_ACTIVE     = 720,
  parameter int V_SYNC_START = 723,
  parameter int V_SYNC_END   = 728,
  parameter int V_TOTAL      = 750,
  parameter int QUEUE_DEPTH  = 16,
  parameter int LINE_WORDS   = 2048
) (
  input  logic                                 vga_clk,
  input  logic                                 reset,
  input  zorro_video_pkg::zorro_in_t          bus,
  output logic                                 slave_n,
  output logic                                 dir,
  output logic [zorro_video_pkg::ZDATA_W-1:0] data_out,
  output logic                                 data_oe,
  output zorro_video_pkg::video_out_t         video
);

  logic [7:0]                           rom_offset;
  logic [zorro_video_pkg::ZDATA_W-1:0] rom_data;
  logic                                 push;
  zorro_video_pkg::wq_entry_t          push_entry;
  zorro_video_pkg::wq_entry_t          head;
  logic                                 not_empty;
  logic                                 pop;
  logic [$clog2(LINE_WORDS)-1:0]        rd_index;
  zorro_video_pkg::pixel_u             rd_pixel;

  ////////////////////////////////////////////////////////////
  // bus side
  ////////////////////////////////////////////////////////////

  zorro_bus_slave #(.LINE_WORDS(LINE_WORDS)) u_zorro_bus_slave (
    .vga_clk(vga_clk), .reset(reset), .bus(bus),
    .rom_offset(rom_offset), .rom_data(rom_data),
    .slave_n(slave_n), .dir(dir), .data_out(data_out), .data_oe(data_oe),
    .push(push), .push_entry(push_entry)
  );

  autoconfig_rom u_autoconfig_rom (
    .vga_clk(vga_clk), .reset(reset), .offset(rom_offset), .rom_data(rom_data)
  );

  write_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) u_write_queue (
    .vga_clk(vga_clk), .reset(reset), .push(push), .push_entry(push_entry),
    .pop(pop), .head(head), .not_empty(not_empty)
  );

  ////////////////////////////////////////////////////////////
  // display side
  ////////////////////////////////////////////////////////////

  line_buffer #(.LINE_WORDS(LINE_WORDS)) u_line_buffer (
    .vga_clk(vga_clk), .reset(reset), .head(head), .not_empty(not_empty),
    .pop(pop), .rd_index(rd_index), .rd_pixel(rd_pixel)
  );

  video_timing #(
    .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
    .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL), .LINE_WORDS(LINE_WORDS)
  ) u_video_timing (
    .vga_clk(vga_clk), .reset(reset), .rd_index(rd_index),
    .rd_pixel(rd_pixel), .video(video)
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic vga_clk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  // 4 ns period
  initial begin
    vga_clk = 1'b0;
    forever #2 vga_clk = ~vga_clk;
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge vga_clk);
    reset <= 1'b0;
  end

endmodule

// ==== bench/zorro_video_tb.sv ====
module zorro_video_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int H_ACTIVE     = 16;
  localparam int H_SYNC_START = 18;
  localparam int H_SYNC_END   = 20;
  localparam int H_TOTAL      = 24;
  localparam int V_ACTIVE     = 4;
  localparam int V_SYNC_START = 5;
  localparam int V_SYNC_END   = 6;
  localparam int V_TOTAL      = 8;
  localparam int QUEUE_DEPTH  = 4;
  localparam int LINE_WORDS   = 16;

  localparam int NUM_ROM      = 24;
  localparam int NUM_IGNORED  = 12;
  localparam int NUM_WRITES   = 40;
  localparam int HOLD_CYCLES  = 8;
  localparam int GAP_CYCLES   = 4;
  localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
  localparam int WATCHDOG_CYCLES = (NUM_ROM + NUM_IGNORED + NUM_WRITES) * 40 +
                                   10 * FRAME_CYCLES;

  logic                        vga_clk;
  logic                        reset;
  zorro_video_pkg::zorro_in_t  bus;
  logic                        slave_n;
  logic                        dir;
  logic [15:0]                 data_out;
  logic                        data_oe;
  zorro_video_pkg::video_out_t video;

  logic [15:0] shadow [LINE_WORDS];
  int          seed   = 32'hcaea;
  int          checks = 0;
  int          errors = 0;

  tb_clock_gen #(.RESET_CYCLES(16)) u_tb_clock_gen (.vga_clk(vga_clk), .reset(reset));

  zorro_video_top #(
    .H_ACTIVE(H_ACTIVE), .H_SYNC_START(H_SYNC_START), .H_SYNC_END(H_SYNC_END),
    .H_TOTAL(H_TOTAL), .V_ACTIVE(V_ACTIVE), .V_SYNC_START(V_SYNC_START),
    .V_SYNC_END(V_SYNC_END), .V_TOTAL(V_TOTAL), .QUEUE_DEPTH(QUEUE_DEPTH),
    .LINE_WORDS(LINE_WORDS)
  ) u_zorro_video_top (
    .vga_clk(vga_clk), .reset(reset), .bus(bus), .slave_n(slave_n), .dir(dir),
    .data_out(data_out), .data_oe(data_oe), .video(video)
  );

  ////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [3:0] rom_nibble(input logic [7:0] offset);
    case (offset)
      8'h00:   return 4'hc;
      8'h02:   return 4'h7;
      8'h04:   return 4'h1;
      8'h06:   return 4'h7;
      8'h08:   return 4'h4;
      8'h10:   return 4'h6;
      8'h12:   return 4'hd;
      8'h14:   return 4'h6;
      8'h16:   return 4'hd;
      default: return 4'h0;
    endcase
  endfunction

  // {red8, green8, blue8} from blue[15:11] green[10:5] red[4:0]
  function automatic logic [23:0] expand_rgb565(input logic [15:0] pixel);
    logic [4:0] r5;
    logic [5:0] g6;
    logic [4:0] b5;
    r5 = pixel[4:0];
    g6 = pixel[10:5];
    b5 = pixel[15:11];
    return {r5, r5[4:2], g6, g6[5:4], b5, b5[4:2]};
  endfunction

  // even offset inside the ram window
  function automatic logic [23:0] ram_offset(input logic [31:0] r);
    logic [23:0] off;
    off = {3'b000, r[20:1], 1'b0};
    if (off >= (zorro_video_pkg::RAM_HIGH - zorro_video_pkg::RAM_LOW)) begin
      off = off - (zorro_video_pkg::RAM_HIGH - zorro_video_pkg::RAM_LOW);
    end
    return off;
  endfunction

  function automatic zorro_video_pkg::zorro_in_t idle_bus();
    zorro_video_pkg::zorro_in_t v;
    v = '0;
    v.cfgin_n = 1'b1;
    v.as_n    = 1'b1;
    v.uds_n   = 1'b1;
    v.lds_n   = 1'b1;
    v.read    = 1'b1;
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (actual === expected) else begin
      errors++;
      $display("mismatch %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  task automatic check_reset_state();
    check_value("reset slave_n", 1, slave_n);
    check_value("reset data_oe", 0, data_oe);
    check_value("reset blank", 1, video.blank);
    check_value("reset colour", 0, {video.red, video.green, video.blue});
  endtask

  ////////////////////////////////////////////////////////////
  // bus cycles
  ////////////////////////////////////////////////////////////

  task automatic drive_bus(input zorro_video_pkg::zorro_in_t v);
    @(posedge vga_clk);
    bus <= v;
  endtask

  // bus must stay untouched by the card
  task automatic quiet_cycles(input int n, input string name);
    repeat (n) begin
      @(negedge vga_clk);
      check_value({name, " slave_n"}, 1, slave_n);
      check_value({name, " data_oe"}, 0, data_oe);
      check_value({name, " dir"}, 1, dir);
    end
  endtask

  task automatic rom_read(input logic [7:0] offset);
    zorro_video_pkg::zorro_in_t v;
    logic [15:0]                expected;
    int                         waited;
    v = idle_bus();
    v.cfgin_n = 1'b0;
    v.as_n    = 1'b0;
    v.doe     = 1'b1;
    v.addr    = zorro_video_pkg::ROM_LOW + 24'(offset);
    expected  = {rom_nibble(offset), 12'h000};
    drive_bus(v);
    waited = 0;
    @(negedge vga_clk);
    while (slave_n && waited < HOLD_CYCLES) begin
      @(negedge vga_clk);
      waited++;
    end
    check_true(!slave_n, $sformatf("no answer to autoconfig read at offset %02h", offset));
    if (!slave_n) begin
      check_value("autoconfig data", expected, data_out);
      check_value("autoconfig data_oe", 1, data_oe);
      check_value("autoconfig dir", 0, dir);
      // data held while doe stays high
      @(negedge vga_clk);
      check_value("autoconfig data hold", expected, data_out);
      check_value("autoconfig slave_n hold", 0, slave_n);
      check_value("autoconfig dir hold", 0, dir);
    end
    drive_bus(idle_bus());
    waited = 0;
    @(negedge vga_clk);
    while (data_oe && waited < HOLD_CYCLES) begin
      @(negedge vga_clk);
      waited++;
    end
    check_true(!data_oe, "data_oe stayed high after doe fell");
    quiet_cycles(GAP_CYCLES, "autoconfig release");
  endtask

  task automatic ignored_cycle(input logic rom_kind, input logic [31:0] r);
    zorro_video_pkg::zorro_in_t v;
    v = idle_bus();
    v.as_n = 1'b0;
    if (rom_kind) begin
      v.addr = zorro_video_pkg::ROM_LOW + 24'(r[7:0]);
      v.doe  = 1'b1;
    end else begin
      v.addr    = zorro_video_pkg::RAM_LOW + ram_offset(r);
      v.cfgin_n = r[8];
      v.doe     = r[9];
    end
    drive_bus(v);
    quiet_cycles(HOLD_CYCLES, rom_kind ? "unconfigured read" : "ram read");
    drive_bus(idle_bus());
    quiet_cycles(GAP_CYCLES, "ignored release");
  endtask

  task automatic host_write(input logic [23:0] off, input logic [15:0] data,
                            input logic [1:0] strobes_n);
    zorro_video_pkg::zorro_in_t v;
    int                         index;
    v = idle_bus();
    v.as_n  = 1'b0;
    v.read  = 1'b0;
    v.uds_n = strobes_n[1];
    v.lds_n = strobes_n[0];
    v.addr  = zorro_video_pkg::RAM_LOW + off;
    v.data  = data;
    index = int'(off[23:1]) % LINE_WORDS;
    if (!strobes_n[1]) begin
      shadow[index][15:8] = data[15:8];
    end
    if (!strobes_n[0]) begin
      shadow[index][7:0] = data[7:0];
    end
    drive_bus(v);
    quiet_cycles(HOLD_CYCLES, "write");
    drive_bus(idle_bus());
    quiet_cycles(GAP_CYCLES, "write release");
  endtask

  ////////////////////////////////////////////////////////////
  // frame scan from the rising edge of vsync
  ////////////////////////////////////////////////////////////

  task automatic check_frame();
    logic prev_vsync;
    int   waited;
    int   col;
    int   active_cnt;
    int   hsync_cnt;
    int   active_lines;
    int   vsync_lines;
    waited = 0;
    @(negedge vga_clk);
    prev_vsync = video.vsync;
    @(negedge vga_clk);
    while (!(video.vsync && !prev_vsync) && waited < 2 * FRAME_CYCLES) begin
      prev_vsync = video.vsync;
      @(negedge vga_clk);
      waited++;
    end
    check_true(video.vsync, "vsync never rose");
    active_cnt   = 0;
    hsync_cnt    = 0;
    active_lines = 0;
    vsync_lines  = 0;
    for (int cyc = 0; cyc < FRAME_CYCLES; cyc++) begin
      if (cyc != 0) begin
        @(negedge vga_clk);
      end
      col = cyc % H_TOTAL;
      if (col == 0) begin
        active_cnt = 0;
        hsync_cnt  = 0;
        if (video.vsync) begin
          vsync_lines++;
        end
      end
      if (!video.blank) begin
        if (active_cnt < LINE_WORDS) begin
          check_value($sformatf("pixel %0d", active_cnt), expand_rgb565(shadow[active_cnt]),
                      {video.red, video.green, video.blue});
        end
        active_cnt++;
      end else begin
        check_value("blanked colour", 0, {video.red, video.green, video.blue});
      end
      if (video.hsync) begin
        hsync_cnt++;
      end
      if (col == H_TOTAL - 1) begin
        check_value("hsync width", H_SYNC_END - H_SYNC_START, hsync_cnt);
        if (active_cnt != 0) begin
          active_lines++;
          check_value("active width", H_ACTIVE, active_cnt);
        end
      end
    end
    check_value("active lines", V_ACTIVE, active_lines);
    check_value("vsync lines", V_SYNC_END - V_SYNC_START, vsync_lines);
  endtask

  initial begin
    logic [31:0] r;
    logic [31:0] r2;
    bus <= idle_bus();
    for (int i = 0; i < LINE_WORDS; i++) begin
      shadow[i] = '0;
    end
    @(posedge vga_clk);
    @(negedge vga_clk);
    while (reset) begin
      check_reset_state();
      @(negedge vga_clk);
    end
    check_reset_state();
    @(negedge vga_clk);
    check_reset_state();

    // mostly real autoconfig offsets, some anywhere in the window
    repeat (NUM_ROM) begin
      r = $random(seed);
      if (r[1:0] != 2'b00) begin
        rom_read({3'b000, r[7:4], 1'b0});
      end else begin
        rom_read(r[15:8]);
      end
    end
    repeat (NUM_IGNORED) begin
      r = $random(seed);
      ignored_cycle(r[0], r);
    end
    check_frame();

    repeat (NUM_WRITES) begin
      r  = $random(seed);
      r2 = $random(seed);
      host_write(ram_offset(r), r2[15:0], (r[22:21] == 2'b11) ? 2'b00 : r[22:21]);
    end
    check_frame();

    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge vga_clk);
    $display("error: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("checks %0d errors %0d", checks, errors);
    $display("Verification failed");
    $finish;
  end

endmodule

// ==== zorro_video_top.f ====
logic/zorro_video_pkg.sv
logic/autoconfig_rom.sv
logic/zorro_bus_slave.sv
logic/write_queue.sv
logic/line_buffer.sv
logic/video_timing.sv
logic/zorro_video_top.sv
bench/tb_clock_gen.sv
bench/zorro_video_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  --top-module zorro_video_tb -f zorro_video_top.f \
  --Mdir obj_dir -o zorro_video_sim \
  || { echo "build failed"; exit 1; }
./obj_dir/zorro_video_sim > sim.log 2>&1
cat sim.log
grep -q "Verification failed" sim.log && exit 1
grep -q "Verification passed" sim.log || exit 1
exit 0
